// File: design/hdr_drop_filter.sv
`timescale 1ns/1ps
`include "hdr_proc_defines.svh"

module hdr_drop_filter (
   input  logic                         axi4s_in,
   input  logic                         arst_n,
   // input stream.
   input  logic                         s_tvalid,
   input  hdr_proc_pkg::data_word_t     s_tdata,
   input  hdr_proc_pkg::keep_t          s_tkeep,
   input  logic                         s_tlast,
   output logic                         s_tready,
   // drop configuration.
   input  logic                         drop_en,
   input  hdr_proc_pkg::drop_mode_e     drop_mode,
   input  hdr_proc_pkg::data_word_t     drop_pattern,
   // filtered stream.
   output logic                         flt_tvalid,
   output hdr_proc_pkg::data_word_t     flt_tdata,
   output hdr_proc_pkg::keep_t          flt_tkeep,
   output logic                         flt_tlast,
   input  logic                         flt_tready,
   output logic [`HDR_CNT_WID-1:0]      drop_count
);

   hdr_proc_pkg::drop_state_e state;
   logic                      match;
   logic                      discard;

   // only the first word of a packet is compared.
   assign match = (state == hdr_proc_pkg::DROP_IDLE) && drop_en && (s_tdata == drop_pattern);

   // words swallowed here, never seen downstream.
   assign discard = (state == hdr_proc_pkg::DROP_DISCARD) ||
                    (match && (drop_mode == hdr_proc_pkg::DROP_WHOLE));

   assign flt_tvalid = s_tvalid && !discard;
   assign flt_tdata  = s_tdata;
   assign flt_tkeep  = match ? '0 : s_tkeep;
   assign flt_tlast  = match ? 1'b1 : s_tlast;
   assign s_tready   = discard || flt_tready;

   // packet position; a match without last starts discarding.
   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         state <= hdr_proc_pkg::DROP_IDLE;
      end else if (s_tvalid && s_tready) begin
         if (s_tlast) state <= hdr_proc_pkg::DROP_IDLE;
         else if (match) state <= hdr_proc_pkg::DROP_DISCARD;
         else if (state == hdr_proc_pkg::DROP_IDLE) state <= hdr_proc_pkg::DROP_PASS;
      end
   end

   // one count per matched packet, held at all ones.
   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         drop_count <= '0;
      end else if (s_tvalid && s_tready && match && (drop_count != '1)) begin
         drop_count <= drop_count + 1'b1;
      end
   end

endmodule

// File: design/hdr_pkt_fifo.sv
`timescale 1ns/1ps
`include "hdr_proc_defines.svh"

module hdr_pkt_fifo (
   input  logic                      axi4s_in,
   input  logic                      arst_n,
   // write side.
   input  logic                      trc_tvalid,
   input  hdr_proc_pkg::data_word_t  trc_tdata,
   input  hdr_proc_pkg::keep_t       trc_tkeep,
   input  logic                      trc_tlast,
   output logic                      trc_tready,
   // read side.
   output logic                      m_tvalid,
   output hdr_proc_pkg::data_word_t  m_tdata,
   output hdr_proc_pkg::keep_t       m_tkeep,
   output logic                      m_tlast,
   input  logic                      m_tready
);

   localparam int DEPTH = `HDR_FIFO_DEPTH;
   localparam int AW    = $clog2(DEPTH);

   // ========================================
   // storage
   // ========================================
   hdr_proc_pkg::data_word_t data_mem [DEPTH];
   hdr_proc_pkg::keep_t      keep_mem [DEPTH];
   logic [DEPTH-1:0]         last_mem;

   // pointers carry one extra wrap bit.
   logic [AW:0] wr_ptr;
   logic [AW:0] rd_ptr;
   logic        full;
   logic        empty;
   logic        wr_en;
   logic        rd_en;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
   assign wr_en = trc_tvalid && trc_tready;
   assign rd_en = m_tvalid && m_tready;

   always_ff @(posedge axi4s_in) begin
      if (wr_en) begin
         data_mem[wr_ptr[AW-1:0]] <= trc_tdata;
         keep_mem[wr_ptr[AW-1:0]] <= trc_tkeep;
         last_mem[wr_ptr[AW-1:0]] <= trc_tlast;
      end
   end

   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;
         if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // head entry read straight from storage, steady until popped.
   assign trc_tready = !full;
   assign m_tvalid   = !empty;
   assign m_tdata    = data_mem[rd_ptr[AW-1:0]];
   assign m_tkeep    = keep_mem[rd_ptr[AW-1:0]];
   assign m_tlast    = last_mem[rd_ptr[AW-1:0]];

endmodule

// File: design/hdr_prefix_insert.sv
`timescale 1ns/1ps
`include "hdr_proc_defines.svh"

module hdr_prefix_insert (
   input  logic                      axi4s_in,
   input  logic                      arst_n,
   // filtered stream in.
   input  logic                      flt_tvalid,
   input  hdr_proc_pkg::data_word_t  flt_tdata,
   input  hdr_proc_pkg::keep_t       flt_tkeep,
   input  logic                      flt_tlast,
   output logic                      flt_tready,
   // prefix configuration, zero to four words.
   input  hdr_proc_pkg::prefix_t     prefix,
   input  logic [2:0]                prefix_words,
   // prefixed stream out.
   output logic                      pfx_tvalid,
   output hdr_proc_pkg::data_word_t  pfx_tdata,
   output hdr_proc_pkg::keep_t       pfx_tkeep,
   output logic                      pfx_tlast,
   input  logic                      pfx_tready
);

   localparam int PFX_IDX_WID = $clog2(`HDR_PREFIX_WORDS);

   // ========================================
   // input register stage
   // ========================================
   logic                     hold_valid;
   hdr_proc_pkg::data_word_t hold_tdata;
   hdr_proc_pkg::keep_t      hold_tkeep;
   logic                     hold_tlast;
   logic                     add_prefix;

   // refill when empty or when the held word leaves this cycle.
   assign flt_tready = !hold_valid || (pfx_tready && !add_prefix);

   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) hold_valid <= 1'b0;
      else if (flt_tready) hold_valid <= flt_tvalid;
   end

   always_ff @(posedge axi4s_in) begin
      if (flt_tvalid && flt_tready) begin
         hold_tdata <= flt_tdata;
         hold_tkeep <= flt_tkeep;
         hold_tlast <= flt_tlast;
      end
   end

   // ========================================
   // prefix insertion
   // ========================================
   hdr_proc_pkg::prefix_state_e state;
   logic [2:0]                  idx;

   // prefix goes out only while the first word waits in the register.
   assign add_prefix = (state == hdr_proc_pkg::PFX_HEAD) && (idx < prefix_words);

   assign pfx_tvalid = hold_valid;
   assign pfx_tdata  = add_prefix ? prefix[idx[PFX_IDX_WID-1:0]] : hold_tdata;
   assign pfx_tkeep  = add_prefix ? '1 : hold_tkeep;
   assign pfx_tlast  = add_prefix ? 1'b0 : hold_tlast;

   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         state <= hdr_proc_pkg::PFX_HEAD;
         idx   <= '0;
      end else if (pfx_tvalid && pfx_tready) begin
         if (add_prefix) begin
            idx <= idx + 3'd1;
         end else if (hold_tlast) begin
            state <= hdr_proc_pkg::PFX_HEAD;
            idx   <= '0;
         end else begin
            state <= hdr_proc_pkg::PFX_BODY;
         end
      end
   end

endmodule

// File: design/hdr_proc_defines.svh
`ifndef HDR_PROC_DEFINES_SVH
`define HDR_PROC_DEFINES_SVH

// ========================================
// stream geometry
// ========================================

// bytes per stream word.
`define HDR_DATA_BYTES 4

// largest prefix, in whole words.
`define HDR_PREFIX_WORDS 4

// ========================================
// buffering and counters
// ========================================

// packet buffer depth in words, a power of two.
`define HDR_FIFO_DEPTH 16

// truncation length and drop counter widths.
`define HDR_LEN_WID 16
`define HDR_CNT_WID 16

`endif

// File: design/hdr_proc_pkg.sv
`include "hdr_proc_defines.svh"

package hdr_proc_pkg;

   // one stream word; byte 0 of the word sits in the top lane, tdata[31:24].
   typedef logic [`HDR_DATA_BYTES-1:0][7:0] data_word_t;

   // keep bit i marks byte i of the word, contiguous from bit 0.
   typedef logic [`HDR_DATA_BYTES-1:0] keep_t;

   // mark keeps an empty last word, whole removes the packet.
   typedef enum logic {DROP_MARK, DROP_WHOLE} drop_mode_e;

   typedef enum logic [1:0] {DROP_IDLE, DROP_PASS, DROP_DISCARD} drop_state_e;
   typedef enum logic {PFX_HEAD, PFX_BODY} prefix_state_e;
   typedef enum logic {TRUNC_KEEP, TRUNC_DISCARD} trunc_state_e;

   // prefix words, entry 0 goes out first.
   typedef data_word_t [`HDR_PREFIX_WORDS-1:0] prefix_t;

endpackage

// File: design/hdr_proc_top.sv
`timescale 1ns/1ps
`include "hdr_proc_defines.svh"

module hdr_proc_top (
   input  logic                      axi4s_in,
   input  logic                      arst_n,
   // input stream.
   input  logic                      s_tvalid,
   input  hdr_proc_pkg::data_word_t  s_tdata,
   input  hdr_proc_pkg::keep_t       s_tkeep,
   input  logic                      s_tlast,
   output logic                      s_tready,
   // output stream.
   output logic                      m_tvalid,
   output hdr_proc_pkg::data_word_t  m_tdata,
   output hdr_proc_pkg::keep_t       m_tkeep,
   output logic                      m_tlast,
   input  logic                      m_tready,
   // configuration, steady while packets are in flight.
   input  logic                      drop_en,
   input  hdr_proc_pkg::drop_mode_e  drop_mode,
   input  hdr_proc_pkg::data_word_t  drop_pattern,
   input  hdr_proc_pkg::prefix_t     prefix,
   input  logic [2:0]                prefix_words,
   input  logic [`HDR_LEN_WID-1:0]   trunc_len,
   // status.
   output logic [`HDR_CNT_WID-1:0]   drop_count
);

   // links between stages; names match the stage ports.
   logic flt_tvalid, flt_tlast, flt_tready;
   logic pfx_tvalid, pfx_tlast, pfx_tready;
   logic trc_tvalid, trc_tlast, trc_tready;
   hdr_proc_pkg::data_word_t flt_tdata, pfx_tdata, trc_tdata;
   hdr_proc_pkg::keep_t      flt_tkeep, pfx_tkeep, trc_tkeep;

   // drop, then prefix, then cut, then buffer.
   hdr_drop_filter u_drop_filter (.*);

   hdr_prefix_insert u_prefix_insert (.*);

   hdr_trunc u_trunc (.*);

   hdr_pkt_fifo u_pkt_fifo (.*);

endmodule

// File: design/hdr_trunc.sv
`timescale 1ns/1ps
`include "hdr_proc_defines.svh"

module hdr_trunc (
   input  logic                      axi4s_in,
   input  logic                      arst_n,
   // prefixed stream in.
   input  logic                      pfx_tvalid,
   input  hdr_proc_pkg::data_word_t  pfx_tdata,
   input  hdr_proc_pkg::keep_t       pfx_tkeep,
   input  logic                      pfx_tlast,
   output logic                      pfx_tready,
   // packet length limit in bytes, never zero.
   input  logic [`HDR_LEN_WID-1:0]   trunc_len,
   // truncated stream out.
   output logic                      trc_tvalid,
   output hdr_proc_pkg::data_word_t  trc_tdata,
   output hdr_proc_pkg::keep_t       trc_tkeep,
   output logic                      trc_tlast,
   input  logic                      trc_tready
);

   localparam int LEN_WID = `HDR_LEN_WID;

   hdr_proc_pkg::trunc_state_e state;
   logic [LEN_WID-1:0]         byte_cnt;
   logic [LEN_WID-1:0]         word_bytes;
   logic [LEN_WID-1:0]         remaining;
   logic                       reach;
   hdr_proc_pkg::keep_t        cut_keep;

   // bytes in this word and bytes still allowed; byte_cnt stays below trunc_len.
   always_comb begin
      word_bytes = '0;
      for (int i = 0; i < `HDR_DATA_BYTES; i++) begin
         word_bytes = word_bytes + LEN_WID'(pfx_tkeep[i]);
         cut_keep[i] = LEN_WID'(i) < remaining;
      end
   end

   assign remaining = trunc_len - byte_cnt;
   assign reach     = word_bytes >= remaining;

   assign trc_tvalid = pfx_tvalid && (state == hdr_proc_pkg::TRUNC_KEEP);
   assign trc_tdata  = pfx_tdata;
   assign trc_tkeep  = reach ? cut_keep : pfx_tkeep;
   assign trc_tlast  = pfx_tlast || reach;
   assign pfx_tready = (state == hdr_proc_pkg::TRUNC_DISCARD) || trc_tready;

   // the limit word closes the packet; the tail is swallowed until last.
   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         state    <= hdr_proc_pkg::TRUNC_KEEP;
         byte_cnt <= '0;
      end else if (pfx_tvalid && pfx_tready) begin
         if (pfx_tlast) begin
            state    <= hdr_proc_pkg::TRUNC_KEEP;
            byte_cnt <= '0;
         end else if ((state == hdr_proc_pkg::TRUNC_KEEP) && reach) begin
            state    <= hdr_proc_pkg::TRUNC_DISCARD;
            byte_cnt <= '0;
         end else if (state == hdr_proc_pkg::TRUNC_KEEP) begin
            byte_cnt <= byte_cnt + word_bytes;
         end
      end
   end

endmodule

// File: dv/hdr_proc_checker.sv
`timescale 1ns/1ps

module hdr_proc_checker (
   input logic                     axi4s_in,
   input logic                     arst_n,
   input logic                     m_tvalid,
   input hdr_proc_pkg::data_word_t m_tdata,
   input hdr_proc_pkg::keep_t      m_tkeep,
   input logic                     m_tlast,
   input logic                     m_tready
);

   // count of failed assertions.
   int fired = 0;

   // a stalled output word holds until it is taken.
   a_stall_hold: assert property (@(posedge axi4s_in) disable iff (!arst_n)
      m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tkeep) && $stable(m_tlast))
      else begin
         $error("output word changed while stalled");
         fired++;
      end

   // nothing leaves while reset is held.
   a_reset_idle: assert property (@(posedge axi4s_in) !arst_n |-> !m_tvalid)
      else begin
         $error("output valid during reset");
         fired++;
      end

   // only the last word of a packet may be short.
   a_full_keep: assert property (@(posedge axi4s_in) disable iff (!arst_n)
      m_tvalid && !m_tlast |-> m_tkeep == '1)
      else begin
         $error("short keep on a word that is not last");
         fired++;
      end

endmodule

bind hdr_proc_top hdr_proc_checker u_checker (
   .axi4s_in(axi4s_in), .arst_n(arst_n),
   .m_tvalid(m_tvalid), .m_tdata(m_tdata), .m_tkeep(m_tkeep),
   .m_tlast(m_tlast), .m_tready(m_tready)
);

// File: dv/hdr_proc_tb.sv
`timescale 1ns/1ps
`include "hdr_proc_defines.svh"

module hdr_proc_tb;

   // time allowed per packet and packets sent over the whole run.
   localparam int PKT_NS     = 400;
   localparam int TOTAL_PKTS = 2 * (25 + 16 + 25) + 3 * 6;

   logic                          axi4s_in;
   logic                          arst_n;
   logic                          s_tvalid;
   hdr_proc_pkg::data_word_t      s_tdata;
   hdr_proc_pkg::keep_t           s_tkeep;
   logic                          s_tlast;
   logic                          s_tready;
   logic                          m_tvalid;
   hdr_proc_pkg::data_word_t      m_tdata;
   hdr_proc_pkg::keep_t           m_tkeep;
   logic                          m_tlast;
   logic                          m_tready;
   logic                          drop_en;
   hdr_proc_pkg::drop_mode_e      drop_mode;
   hdr_proc_pkg::data_word_t      drop_pattern;
   hdr_proc_pkg::prefix_t         prefix;
   logic [2:0]                    prefix_words;
   logic [`HDR_LEN_WID-1:0]       trunc_len;
   logic [`HDR_CNT_WID-1:0]       drop_count;

   // expected and received bytes in order with one length per packet.
   logic [7:0] exp_data [$];
   logic [7:0] got_data [$];
   int         exp_len [$];
   int         got_len [$];
   int         cur_len;
   int         errors;
   int         drops_exp;
   int         pkts;
   int         tests;
   int         seed;
   logic       stall_en;

   hdr_proc_top DUT (.*);

   // ========================================
   // clock, stalls and watchdog
   // ========================================
   always #2 axi4s_in = ~axi4s_in;

   // output stalls about one cycle in four.
   always @(posedge axi4s_in) begin
      #1;
      m_tready = !stall_en || (($random(seed) & 3) != 0);
   end

   initial begin
      #(TOTAL_PKTS * PKT_NS);
      $display("timeout: %0d expected packets never came out of the DUT", exp_len.size());
      $display("FAIL: see errors above");
      $finish;
   end

   // ========================================
   // reference model
   // ========================================
   // fixed byte table that permutes 0..255.
   function automatic logic [7:0] tab(input int k);
      return 8'((k * 37 + 11) % 256);
   endfunction

   // four table bytes as one word with byte 0 in the top lane.
   function automatic hdr_proc_pkg::data_word_t tab_word(input int off);
      hdr_proc_pkg::data_word_t w;
      for (int k = 0; k < 4; k++) w[3-k] = tab(off + k);
      return w;
   endfunction

   // drop rule first, then prefix, then truncation.
   function automatic void expect_pkt(input int off, input int n);
      logic [7:0] b [$];
      logic       hit;
      hit = drop_en;
      for (int k = 0; k < 4; k++) begin
         if (tab(off + k) != drop_pattern[3-k]) hit = 1'b0;
      end
      if (hit) drops_exp++;
      if (hit && (drop_mode == hdr_proc_pkg::DROP_WHOLE)) return;
      for (int w = 0; w < prefix_words; w++) begin
         for (int k = 0; k < 4; k++) b.push_back(prefix[w][3-k]);
      end
      // a marked packet keeps only its prefix.
      if (!hit) begin
         for (int k = 0; k < n; k++) b.push_back(tab(off + k));
      end
      while (b.size() > trunc_len) void'(b.pop_back());
      exp_len.push_back(b.size());
      foreach (b[k]) exp_data.push_back(b[k]);
   endfunction

   task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         errors++;
         $display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   // ========================================
   // stimulus
   // ========================================
   // sends n table bytes from offset off as full words and a short last word.
   task automatic send_pkt(input int off, input int n);
      expect_pkt(off, n);
      for (int pos = 0; pos < n; pos += 4) begin
         s_tvalid = 1'b1;
         s_tlast  = (pos + 4 >= n);
         for (int k = 0; k < 4; k++) begin
            s_tdata[3-k] = (pos + k < n) ? tab(off + pos + k) : 8'h00;
            s_tkeep[k]   = (pos + k < n);
         end
         // ready is steady from here to the next rising edge.
         do @(negedge axi4s_in); while (!s_tready);
         @(posedge axi4s_in);
         #1;
      end
      s_tvalid = 1'b0;
   endtask

   // waits for all expected packets and lets discarded tails clear the stages.
   task automatic drain();
      while (exp_len.size() != 0) @(posedge axi4s_in);
      repeat (4) @(posedge axi4s_in);
      #1;
   endtask

   task automatic report(input string name);
      tests++;
      $display("test %s done, %0d packets checked, %0d errors so far", name, pkts, errors);
   endtask

   // header of 16 bytes plus 0 to 24 payload bytes.
   task automatic packet_run(input string name, input int pw, input int len, input int step);
      drop_en      = 1'b0;
      prefix_words = 3'(pw);
      trunc_len    = 16'(len);
      for (int p = 0; p <= 24; p++) send_pkt(p * step + 3, 16 + p);
      drain();
      report(name);
   endtask

   task automatic trunc_sweep(input string name);
      drop_en      = 1'b0;
      prefix_words = 3'd0;
      for (int t = 1; t <= 16; t++) begin
         trunc_len = 16'(t);
         send_pkt(t * 11, 20);
         drain();
      end
      report(name);
   endtask

   // odd packets match the pattern and even ones are neighbors.
   task automatic drop_run(input string name, input hdr_proc_pkg::drop_mode_e mode, input int pw);
      drop_en      = 1'b1;
      drop_mode    = mode;
      drop_pattern = tab_word(100);
      prefix_words = 3'(pw);
      trunc_len    = 16'd64;
      for (int i = 0; i < 6; i++) send_pkt((i % 2 == 1) ? 100 : 90 + i * 10, 20 + i);
      drain();
      check_eq(32'(drop_count), 32'(drops_exp), "drop count");
      report(name);
   endtask

   // ========================================
   // collection and comparison
   // ========================================
   // a word valid and ready at the falling edge moves on the next rising edge.
   always @(negedge axi4s_in) begin
      if (arst_n && m_tvalid && m_tready) begin
         for (int k = 0; k < 4; k++) begin
            if (m_tkeep[k]) begin
               got_data.push_back(m_tdata[3-k]);
               cur_len++;
            end
         end
         if (m_tlast) begin
            got_len.push_back(cur_len);
            cur_len = 0;
         end
      end
   end

   always @(posedge axi4s_in) begin
      int n;
      int e;
      if (got_len.size() != 0) begin
         n = got_len.pop_front();
         if (exp_len.size() == 0) begin
            // no packet was expected here and every byte is surplus.
            errors++;
            $display("unexpected output packet of %0d bytes at %0t ns", n, $time);
            repeat (n) void'(got_data.pop_front());
         end else begin
            e = exp_len.pop_front();
            check_eq(n, e, "packet length");
            for (int k = 0; (k < n) || (k < e); k++) begin
               if ((k < n) && (k < e)) check_eq(got_data[0], exp_data[0], "packet byte");
               if (k < n) void'(got_data.pop_front());
               if (k < e) void'(exp_data.pop_front());
            end
         end
         pkts++;
      end
   end

   // ========================================
   // test sequence
   // ========================================
   initial begin
      seed         = 13;
      stall_en     = 1'b0;
      axi4s_in     = 1'b0;
      arst_n       = 1'b0;
      s_tvalid     = 1'b0;
      s_tdata      = '0;
      s_tkeep      = '0;
      s_tlast      = 1'b0;
      m_tready     = 1'b1;
      drop_en      = 1'b0;
      drop_mode    = hdr_proc_pkg::DROP_MARK;
      drop_pattern = '0;
      prefix_words = 3'd0;
      trunc_len    = 16'd64;
      for (int w = 0; w < 4; w++) prefix[w] = tab_word(200 + 4 * w);
      repeat (4) @(posedge axi4s_in);
      #1;
      arst_n = 1'b1;
      packet_run("passthrough", 0, 64, 7);
      trunc_sweep("truncation");
      packet_run("prefix growth", 4, 32, 5);
      drop_run("mark drop", hdr_proc_pkg::DROP_MARK, 0);
      drop_run("mark drop with prefix", hdr_proc_pkg::DROP_MARK, 4);
      drop_run("whole drop", hdr_proc_pkg::DROP_WHOLE, 2);
      stall_en = 1'b1;
      packet_run("passthrough with stalls", 0, 64, 7);
      trunc_sweep("truncation with stalls");
      packet_run("prefix growth with stalls", 4, 32, 5);
      $display("tests %0d, packets %0d, errors %0d, assertion failures %0d",
               tests, pkts, errors, DUT.u_checker.fired);
      if ((errors == 0) && (DUT.u_checker.fired == 0)) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: filelist.f
+incdir+design
design/hdr_proc_pkg.sv
design/hdr_drop_filter.sv
design/hdr_prefix_insert.sv
design/hdr_trunc.sv
design/hdr_pkt_fifo.sv
design/hdr_proc_top.sv
dv/hdr_proc_checker.sv
dv/hdr_proc_tb.sv

// File: run.sh
#!/bin/sh
# build and run the header processor testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module hdr_proc_tb
out=$(./obj_dir/Vhdr_proc_tb +verilator+error+limit+1000 2>&1 || true)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'PASS: all tests'; then
   exit 0
fi
exit 1
